// ==== verilog/stq_ctrl_pkg.sv ====
package stq_ctrl_pkg;

  // command opcodes on the input port
  typedef enum logic [2:0] {
    op_store_addr = 3'd0,
    op_store_data = 3'd1,
    op_retire     = 3'd2,
    op_drain      = 3'd3,
    op_flush      = 3'd4,
    op_load_check = 3'd5
  } stq_op_e;

  // per-entry lifecycle where a retired entry always holds data
  typedef enum logic [1:0] {
    st_free    = 2'd0,
    st_addr    = 2'd1,
    st_full    = 2'd2,
    st_retired = 2'd3
  } entry_state_e;

  typedef enum logic [1:0] {
    res_miss     = 2'd0,
    res_forward  = 2'd1,
    res_conflict = 2'd2
  } result_kind_e;

endpackage

// ==== verilog/stq_types_pkg.sv ====
package stq_types_pkg;

  // one command on the input port
  typedef struct packed {
    stq_ctrl_pkg::stq_op_e op;
    logic [31:0]           addr;
    logic [3:0]            mask;
    logic [31:0]           data;
    logic [4:0]            idx;
  } stq_cmd_t;

  // broadcast to every entry
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic        ld;
  } entry_cmd_t;

  typedef struct packed {
    stq_ctrl_pkg::result_kind_e kind;
    logic [4:0]                 idx;
    logic [31:0]                data;
  } load_result_t;

endpackage

// ==== verilog/stq_cmd_decode.sv ====
module stq_cmd_decode #(
  parameter int DEPTH  = 8,
  parameter int ADDR_W = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  stq_types_pkg::stq_cmd_t    cmd,
  input  logic                       cmd_valid,
  input  logic                       res_pending,
  input  logic                       res_ready,
  input  logic                       head_retired,
  output logic                       cmd_ready,
  output logic [DEPTH-1:0]           alloc_en,
  output logic [DEPTH-1:0]           data_en,
  output logic [DEPTH-1:0]           retire_en,
  output logic [DEPTH-1:0]           free_en,
  output logic                       flush_en,
  output logic                       chk_en,
  output stq_types_pkg::entry_cmd_t  ecmd,
  output logic [$clog2(DEPTH)-1:0]   head
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [IDX_W-1:0] tail;
  logic [IDX_W-1:0] rptr;
  logic [CNT_W-1:0] used_cnt;
  logic [CNT_W-1:0] ret_cnt;
  // allocated but not retired
  logic [DEPTH-1:0] pend;
  // data written
  logic [DEPTH-1:0] filled;

  logic             full;
  logic             acc;
  logic [IDX_W-1:0] data_idx;
  logic             data_ok;
  logic             retire_ok;
  logic             do_alloc;
  logic             do_data;
  logic             do_retire;
  logic             do_drain;

  function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
    return (p == IDX_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = (used_cnt == CNT_W'(DEPTH));

  always_comb begin
    case (cmd.op)
      stq_ctrl_pkg::op_store_addr: cmd_ready = !full;
      stq_ctrl_pkg::op_load_check: cmd_ready = !res_pending || res_ready;
      stq_ctrl_pkg::op_drain:      cmd_ready = head_retired;
      default:                     cmd_ready = 1'b1;
    endcase
  end

  assign acc = cmd_valid && cmd_ready;

  // data and retire only land on entries in the right state
  assign data_idx  = cmd.idx[IDX_W-1:0];
  assign data_ok   = (int'(cmd.idx) < DEPTH) && pend[data_idx] && !filled[data_idx];
  assign retire_ok = pend[rptr] && filled[rptr];

  assign do_alloc  = acc && (cmd.op == stq_ctrl_pkg::op_store_addr);
  assign do_data   = acc && (cmd.op == stq_ctrl_pkg::op_store_data) && data_ok;
  assign do_retire = acc && (cmd.op == stq_ctrl_pkg::op_retire) && retire_ok;
  assign do_drain  = acc && (cmd.op == stq_ctrl_pkg::op_drain);
  assign flush_en  = acc && (cmd.op == stq_ctrl_pkg::op_flush);
  assign chk_en    = acc && (cmd.op == stq_ctrl_pkg::op_load_check);

  assign alloc_en  = do_alloc  ? DEPTH'(1) << tail     : '0;
  assign data_en   = do_data   ? DEPTH'(1) << data_idx : '0;
  assign retire_en = do_retire ? DEPTH'(1) << rptr     : '0;
  assign free_en   = do_drain  ? DEPTH'(1) << head     : '0;

  always_comb begin
    ecmd.addr = 32'(cmd.addr[ADDR_W-1:0]);
    ecmd.mask = cmd.mask;
    ecmd.data = cmd.data;
    ecmd.ld   = (cmd.op == stq_ctrl_pkg::op_load_check);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail     <= '0;
      rptr     <= '0;
      head     <= '0;
      used_cnt <= '0;
      ret_cnt  <= '0;
      pend     <= '0;
      filled   <= '0;
    end else begin
      if (do_alloc) begin
        tail         <= next_ptr(tail);
        used_cnt     <= used_cnt + 1'b1;
        pend[tail]   <= 1'b1;
        filled[tail] <= 1'b0;
      end
      if (do_data) begin
        filled[data_idx] <= 1'b1;
      end
      if (do_retire) begin
        rptr       <= next_ptr(rptr);
        ret_cnt    <= ret_cnt + 1'b1;
        pend[rptr] <= 1'b0;
      end
      if (do_drain) begin
        head         <= next_ptr(head);
        used_cnt     <= used_cnt - 1'b1;
        ret_cnt      <= ret_cnt - 1'b1;
        filled[head] <= 1'b0;
      end
      // retired entries in head..rptr-1 are the only survivors
      if (flush_en) begin
        tail     <= rptr;
        used_cnt <= ret_cnt;
        pend     <= '0;
        filled   <= filled & ~pend;
      end
    end
  end

endmodule

// ==== verilog/stq_entry.sv ====
module stq_entry #(
  parameter int ADDR_W = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          alloc_en,
  input  logic                          data_en,
  input  logic                          retire_en,
  input  logic                          free_en,
  input  logic                          flush_en,
  input  logic                          chk_en,
  input  stq_types_pkg::entry_cmd_t     ecmd,
  output stq_ctrl_pkg::entry_state_e    state,
  output logic                          match,
  output logic                          partial,
  output logic [31:0]                   data
);

  logic [ADDR_W-1:0] addr_q;
  logic [3:0]        mask_q;
  logic [31:0]       data_q;

  logic live;
  logic has_data;
  logic overlap;
  logic covered;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stq_ctrl_pkg::st_free;
    end else if (alloc_en) begin
      state <= stq_ctrl_pkg::st_addr;
    end else if (data_en) begin
      state <= stq_ctrl_pkg::st_full;
    end else if (retire_en) begin
      state <= stq_ctrl_pkg::st_retired;
    end else if (free_en) begin
      state <= stq_ctrl_pkg::st_free;
    end else if (flush_en && state != stq_ctrl_pkg::st_retired) begin
      state <= stq_ctrl_pkg::st_free;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      addr_q <= ecmd.addr[ADDR_W-1:0];
      mask_q <= ecmd.mask;
    end
    if (data_en) begin
      data_q <= ecmd.data;
    end
  end

  assign live     = (state != stq_ctrl_pkg::st_free);
  assign has_data = (state == stq_ctrl_pkg::st_full) || (state == stq_ctrl_pkg::st_retired);

  // same word and at least one shared byte
  assign overlap = chk_en && ecmd.ld && live &&
                   (addr_q == ecmd.addr[ADDR_W-1:0]) && ((mask_q & ecmd.mask) != 4'b0000);

  // every load byte written by this store
  assign covered = ((ecmd.mask & ~mask_q) == 4'b0000);

  assign match   = overlap && has_data && covered;
  assign partial = overlap && !match;
  assign data    = data_q;

endmodule

// ==== verilog/stq_entry_array.sv ====
module stq_entry_array #(
  parameter int DEPTH  = 8,
  parameter int ADDR_W = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [DEPTH-1:0]            alloc_en,
  input  logic [DEPTH-1:0]            data_en,
  input  logic [DEPTH-1:0]            retire_en,
  input  logic [DEPTH-1:0]            free_en,
  input  logic                        flush_en,
  input  logic                        chk_en,
  input  stq_types_pkg::entry_cmd_t   ecmd,
  input  logic [$clog2(DEPTH)-1:0]    head,
  output logic [DEPTH-1:0]            match,
  output logic [DEPTH-1:0]            partial,
  output logic [DEPTH-1:0][31:0]      entry_data,
  output logic                        head_state_retired
);

  stq_ctrl_pkg::entry_state_e state [DEPTH];

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    stq_entry #(
      .ADDR_W(ADDR_W)
    ) u_entry (
      .clk      (clk),
      .rst      (rst),
      .alloc_en (alloc_en[i]),
      .data_en  (data_en[i]),
      .retire_en(retire_en[i]),
      .free_en  (free_en[i]),
      .flush_en (flush_en),
      .chk_en   (chk_en),
      .ecmd     (ecmd),
      .state    (state[i]),
      .match    (match[i]),
      .partial  (partial[i]),
      .data     (entry_data[i])
    );
  end

  // drain waits on this
  assign head_state_retired = (state[head] == stq_ctrl_pkg::st_retired);

endmodule

// ==== verilog/stq_fwd_select.sv ====
module stq_fwd_select #(
  parameter int DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          chk_en,
  input  logic [DEPTH-1:0]              match,
  input  logic [DEPTH-1:0]              partial,
  input  logic [DEPTH-1:0][31:0]        entry_data,
  input  logic [$clog2(DEPTH)-1:0]      head,
  input  logic                          res_ready,
  output stq_types_pkg::load_result_t   res,
  output logic                          res_valid,
  output logic                          res_pending
);

  stq_types_pkg::load_result_t res_nxt;

  // walk oldest to youngest so a later hit overrides an earlier one
  always_comb begin
    int pos;
    res_nxt.kind = stq_ctrl_pkg::res_miss;
    res_nxt.idx  = '0;
    res_nxt.data = '0;
    for (int d = 0; d < DEPTH; d++) begin
      pos = int'(head) + d;
      if (pos >= DEPTH) begin
        pos = pos - DEPTH;
      end
      if (match[pos]) begin
        res_nxt.kind = stq_ctrl_pkg::res_forward;
        res_nxt.idx  = 5'(pos);
        res_nxt.data = entry_data[pos];
      end else if (partial[pos]) begin
        res_nxt.kind = stq_ctrl_pkg::res_conflict;
        res_nxt.idx  = 5'(pos);
        res_nxt.data = '0;
      end
    end
  end

  // decode holds off a new check while a result is stuck
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (chk_en) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (chk_en) begin
      res <= res_nxt;
    end
  end

  assign res_pending = res_valid;

endmodule

// ==== verilog/store_queue.sv ====
module store_queue #(
  parameter int DEPTH  = 8,
  parameter int ADDR_W = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  stq_types_pkg::stq_cmd_t       cmd,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  output stq_types_pkg::load_result_t   res,
  output logic                          res_valid,
  input  logic                          res_ready
);

  logic [DEPTH-1:0]           alloc_en;
  logic [DEPTH-1:0]           data_en;
  logic [DEPTH-1:0]           retire_en;
  logic [DEPTH-1:0]           free_en;
  logic                       flush_en;
  logic                       chk_en;
  stq_types_pkg::entry_cmd_t  ecmd;
  logic [$clog2(DEPTH)-1:0]   head;
  logic                       head_retired;
  logic [DEPTH-1:0]           match;
  logic [DEPTH-1:0]           partial;
  logic [DEPTH-1:0][31:0]     entry_data;
  logic                       res_pending;

  stq_cmd_decode #(
    .DEPTH (DEPTH),
    .ADDR_W(ADDR_W)
  ) u_decode (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .res_pending (res_pending),
    .res_ready   (res_ready),
    .head_retired(head_retired),
    .cmd_ready   (cmd_ready),
    .alloc_en    (alloc_en),
    .data_en     (data_en),
    .retire_en   (retire_en),
    .free_en     (free_en),
    .flush_en    (flush_en),
    .chk_en      (chk_en),
    .ecmd        (ecmd),
    .head        (head)
  );

  stq_entry_array #(
    .DEPTH (DEPTH),
    .ADDR_W(ADDR_W)
  ) u_array (
    .clk               (clk),
    .rst               (rst),
    .alloc_en          (alloc_en),
    .data_en           (data_en),
    .retire_en         (retire_en),
    .free_en           (free_en),
    .flush_en          (flush_en),
    .chk_en            (chk_en),
    .ecmd              (ecmd),
    .head              (head),
    .match             (match),
    .partial           (partial),
    .entry_data        (entry_data),
    .head_state_retired(head_retired)
  );

  stq_fwd_select #(
    .DEPTH(DEPTH)
  ) u_select (
    .clk        (clk),
    .rst        (rst),
    .chk_en     (chk_en),
    .match      (match),
    .partial    (partial),
    .entry_data (entry_data),
    .head       (head),
    .res_ready  (res_ready),
    .res        (res),
    .res_valid  (res_valid),
    .res_pending(res_pending)
  );

endmodule

// ==== tests/store_queue_properties.sv ====
module store_queue_properties #(
  parameter int DEPTH = 8
) (
  input logic                         clk,
  input logic                         rst,
  input logic [$clog2(DEPTH+1)-1:0]   used_cnt,
  input logic [DEPTH-1:0]             pend,
  input logic [DEPTH-1:0]             filled,
  input logic                         cmd_valid,
  input stq_ctrl_pkg::stq_op_e        op,
  input logic                         cmd_ready,
  input logic [DEPTH-1:0]             alloc_en
);

  logic [DEPTH-1:0] live;

  // an entry is live while allocated or still holding retired data
  assign live = pend | filled;

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    int'(used_cnt) <= DEPTH)
    else $error("used entry count above DEPTH");

  // no allocation into a full queue
  a_full_stall: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && op == stq_ctrl_pkg::op_store_addr && (&live)) |-> !cmd_ready)
    else $error("store address not stalled on a full queue");

  a_alloc_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(alloc_en) && ((alloc_en & live) == '0))
    else $error("allocation not one-hot or into a live entry");

endmodule

bind stq_cmd_decode store_queue_properties #(
  .DEPTH(DEPTH)
) u_props (
  .clk      (clk),
  .rst      (rst),
  .used_cnt (used_cnt),
  .pend     (pend),
  .filled   (filled),
  .cmd_valid(cmd_valid),
  .op       (cmd.op),
  .cmd_ready(cmd_ready),
  .alloc_en (alloc_en)
);

// ==== tests/store_queue_checker.sv ====
module store_queue_checker (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         res_valid,
  input  logic                         res_ready,
  input  stq_types_pkg::load_result_t  res,
  input  logic                         exp_push,
  input  stq_types_pkg::load_result_t  expected,
  input  logic                         report,
  input  int                           flow_errors,
  output int                           errors,
  output int                           pending
);

  stq_types_pkg::load_result_t exp_q[$];
  int tests;

  initial begin
    errors  = 0;
    pending = 0;
    tests   = 0;
  end

  // handshake sampled on the edge where it takes effect
  always @(posedge clk) begin : compare
    stq_types_pkg::load_result_t e;
    if (!rst) begin
      if (exp_push) begin
        exp_q.push_back(expected);
      end
      if (res_valid && res_ready) begin
        if (exp_q.size() == 0) begin
          $display("a load result arrived with no expected value at time %0t", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          tests++;
          if (res !== e) begin
            $display("[ERROR] %0t test %0d: got %s idx %0d data %h, expected %s idx %0d data %h",
                     $time, tests, res.kind.name(), res.idx, res.data,
                     e.kind.name(), e.idx, e.data);
            errors++;
          end else begin
            $display("test %0d passed: %s idx %0d data %h",
                     tests, res.kind.name(), res.idx, res.data);
          end
        end
      end
      pending = exp_q.size();
    end
  end

  always @(posedge report) begin
    $display("results checked %0d, result errors %0d, flow errors %0d, results missing %0d",
             tests, errors, flow_errors, pending);
  end

endmodule

// ==== tests/store_queue_tb.sv ====
module store_queue_tb;

  localparam int DEPTH       = 8;
  localparam int ADDR_W      = 16;
  localparam int CMD_TIMEOUT = 50;
  localparam int RES_TIMEOUT = 200;
  localparam int HOLD_CYCLES = 10;

  logic                         clk;
  logic                         rst;
  stq_types_pkg::stq_cmd_t      cmd;
  logic                         cmd_valid;
  logic                         cmd_ready;
  stq_types_pkg::load_result_t  res;
  logic                         res_valid;
  logic                         res_ready;
  logic                         exp_push;
  stq_types_pkg::load_result_t  exp_res;
  logic                         report;
  int                           flow_errors;
  int                           errors;
  int                           pending;

  store_queue #(
    .DEPTH (DEPTH),
    .ADDR_W(ADDR_W)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .res      (res),
    .res_valid(res_valid),
    .res_ready(res_ready)
  );

  store_queue_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res        (res),
    .exp_push   (exp_push),
    .expected   (exp_res),
    .report     (report),
    .flow_errors(flow_errors),
    .errors     (errors),
    .pending    (pending)
  );

  always #5 clk = ~clk;

  // random back-pressure on the result port
  always @(negedge clk) begin
    res_ready = ($urandom_range(0, 4) > 1);
  end

  // starts and ends on a falling edge
  task automatic send(input stq_types_pkg::stq_cmd_t c, input logic hold,
                      input stq_types_pkg::load_result_t e, output logic ok);
    int waited;
    waited    = 0;
    ok        = 1'b1;
    cmd       = c;
    cmd_valid = 1'b1;
    #1;
    if (hold) begin
      while (waited < HOLD_CYCLES) begin
        if (cmd_ready) begin
          $display("a store address was accepted by a full queue at time %0t", $time);
          flow_errors++;
          cmd_valid = 1'b0;
          waited    = HOLD_CYCLES;
        end else begin
          @(negedge clk);
          #1;
          waited++;
        end
      end
      cmd_valid = 1'b0;
      @(negedge clk);
    end else begin
      while (!cmd_ready && waited < CMD_TIMEOUT) begin
        @(negedge clk);
        #1;
        waited++;
      end
      if (!cmd_ready) begin
        $display("timed out waiting for cmd_ready on %s at time %0t", c.op.name(), $time);
        cmd_valid = 1'b0;
        ok        = 1'b0;
      end else begin
        if (c.op == stq_ctrl_pkg::op_load_check) begin
          exp_push = 1'b1;
          exp_res  = e;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        exp_push  = 1'b0;
      end
    end
  endtask

  initial begin : main
    int                           fd;
    int                           n;
    int                           waited;
    string                        line;
    logic [31:0]                  f_op;
    logic [31:0]                  f_addr;
    logic [31:0]                  f_mask;
    logic [31:0]                  f_data;
    logic [31:0]                  f_idx;
    logic [31:0]                  f_kind;
    logic [31:0]                  f_eidx;
    logic [31:0]                  f_edata;
    stq_types_pkg::stq_cmd_t      c;
    stq_types_pkg::load_result_t  e;
    logic                         ok;
    logic                         stop;

    clk         = 1'b0;
    rst         = 1'b1;
    cmd         = '0;
    cmd_valid   = 1'b0;
    res_ready   = 1'b0;
    exp_push    = 1'b0;
    exp_res     = '0;
    report      = 1'b0;
    flow_errors = 0;
    stop        = 1'b0;
    void'($urandom(32'heb93_790a));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("tests/store_queue_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/store_queue_golden.txt");
      stop = 1'b1;
    end else begin
      while (!stop && $fgets(line, fd) > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    f_op, f_addr, f_mask, f_data, f_idx, f_kind, f_eidx, f_edata);
        // comment and blank lines give fewer fields
        if (n == 8) begin
          c.op   = stq_ctrl_pkg::stq_op_e'(f_op[2:0]);
          c.addr = f_addr;
          c.mask = f_mask[3:0];
          c.data = f_data;
          c.idx  = f_idx[4:0];
          e.kind = stq_ctrl_pkg::result_kind_e'(f_kind[1:0]);
          e.idx  = f_eidx[4:0];
          e.data = f_edata;
          send(c, f_kind == 32'd3, e, ok);
          if (!ok) begin
            stop = 1'b1;
          end
        end
      end
      $fclose(fd);
    end

    waited = 0;
    while (!stop && pending != 0 && waited < RES_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!stop && pending != 0) begin
      $display("timed out waiting for %0d load results", pending);
      stop = 1'b1;
    end

    report = 1'b1;
    #1;
    if (!stop && errors == 0 && flow_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== store_queue.f ====
verilog/stq_ctrl_pkg.sv
verilog/stq_types_pkg.sv
verilog/stq_cmd_decode.sv
verilog/stq_entry.sv
verilog/stq_entry_array.sv
verilog/stq_fwd_select.sv
verilog/store_queue.sv
tests/store_queue_properties.sv
tests/store_queue_checker.sv
tests/store_queue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module store_queue_tb -f store_queue.f -o sim_store_queue \
  && ./obj_dir/sim_store_queue > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// ==== tests/store_queue_golden.txt ====
# op addr mask data idx kind eidx edata, all hex; the last three are the load result
# op 0 st_addr 1 st_data 2 retire 3 drain 4 flush 5 load; kind 3 on a store means refused
# full forward
0 00000100 f 00000000 00 0 00 00000000
1 00000000 0 11223344 00 0 00 00000000
5 00000100 3 00000000 00 1 00 11223344
# conflict and miss
0 00000200 3 00000000 00 0 00 00000000
5 00000200 1 00000000 00 2 01 00000000
1 00000000 0 aabbccdd 01 0 00 00000000
5 00000200 f 00000000 00 2 01 00000000
5 00000300 f 00000000 00 0 00 00000000
5 00000200 c 00000000 00 0 00 00000000
# youngest wins
0 00000400 f 00000000 00 0 00 00000000
1 00000000 0 01010101 02 0 00 00000000
0 00000400 f 00000000 00 0 00 00000000
1 00000000 0 02020202 03 0 00 00000000
5 00000400 f 00000000 00 1 03 02020202
# retire, drain, flush
2 00000000 0 00000000 00 0 00 00000000
2 00000000 0 00000000 00 0 00 00000000
3 00000000 0 00000000 00 0 00 00000000
3 00000000 0 00000000 00 0 00 00000000
5 00000100 f 00000000 00 0 00 00000000
5 00000200 3 00000000 00 0 00 00000000
2 00000000 0 00000000 00 0 00 00000000
4 00000000 0 00000000 00 0 00 00000000
5 00000400 f 00000000 00 1 02 01010101
3 00000000 0 00000000 00 0 00 00000000
# full queue
0 00000500 f 00000000 00 0 00 00000000
0 00000501 f 00000000 00 0 00 00000000
0 00000502 f 00000000 00 0 00 00000000
0 00000503 f 00000000 00 0 00 00000000
0 00000504 f 00000000 00 0 00 00000000
0 00000505 f 00000000 00 0 00 00000000
0 00000506 f 00000000 00 0 00 00000000
0 00000507 f 00000000 00 0 00 00000000
0 00000508 f 00000000 00 3 00 00000000
1 00000000 0 50505050 03 0 00 00000000
2 00000000 0 00000000 00 0 00 00000000
3 00000000 0 00000000 00 0 00 00000000
0 00000508 f 00000000 00 0 00 00000000
5 00000508 f 00000000 00 2 03 00000000
# back to back loads
1 00000000 0 55555501 04 0 00 00000000
5 00000501 f 00000000 00 1 04 55555501
5 00000502 f 00000000 00 2 05 00000000
5 00000600 f 00000000 00 0 00 00000000
5 00000501 1 00000000 00 1 04 55555501
